// ==== verilog/ipt_macros.svh ====
`ifndef IPT_MACROS_SVH
`define IPT_MACROS_SVH

// ====================
// page table geometry
// ====================

// slot index bits per bank, 512 slots each
`define IPT_INDEX_BITS 9

// cycles from the edge sampling req_i to the edge raising resp_valid_o
`define IPT_LATENCY 3

// ====================
// configuration map
// ====================

// command on write, probe status on read
`define IPT_REG_CMD  2'd0
`define IPT_REG_SLOT 2'd1
`define IPT_REG_ATTR 2'd2
`define IPT_REG_VPN  2'd3

`endif

// ==== verilog/ipt_pkg.sv ====
`include "ipt_macros.svh"

package ipt_pkg;

	// one page table entry as stored in a bank
	// drwx holds dirty, read, write and execute from high to low
	typedef struct packed {
		logic [7:0]  asid;
		logic        last;
		logic [18:0] vpn;
		logic [3:0]  drwx;
	} ipt_pte_t;

	// configuration write data, read as a command or as entry attributes
	// depending on the register address
	typedef union packed {
		struct packed {
			logic [28:0] rsvd;
			logic        bank;
			logic        probe;
			logic        insert;
		} cmd;
		ipt_pte_t attr;
	} ipt_cfg_word_u;

	// bank 0 index uses the page number only
	function automatic logic [`IPT_INDEX_BITS-1:0] ipt_hash0(input logic [18:0] vpn);
		return vpn[`IPT_INDEX_BITS-1:0];
	endfunction

	// bank 1 folds the ASID in so that address spaces spread over the bank
	function automatic logic [`IPT_INDEX_BITS-1:0] ipt_hash1(
		input logic [7:0]  asid,
		input logic [18:0] vpn
	);
		return vpn[`IPT_INDEX_BITS-1:0] ^ {asid, 1'b1};
	endfunction

	// an entry without any access right counts as an empty slot
	function automatic logic ipt_pte_valid(input ipt_pte_t pte);
		return |pte.drwx[2:0];
	endfunction

endpackage

// ==== verilog/ipt_cfg_regs.sv ====
`timescale 1ns/1ps
`include "ipt_macros.svh"

module ipt_cfg_regs import ipt_pkg::*; (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       cfg_we_i,
	input  logic                       cfg_re_i,
	input  logic [1:0]                 cfg_adr_i,
	input  logic [31:0]                cfg_dat_i,
	output logic [31:0]                cfg_dat_o,
	input  logic                       req_i,
	input  logic [63:0]                vadr_i,
	input  logic                       probe_done_i,
	input  logic                       probe_hit_i,
	input  logic                       probe_bank_i,
	input  logic [`IPT_INDEX_BITS-1:0] probe_slot_i,
	output logic                       probe_issue_o,
	output logic [7:0]                 key_asid_o,
	output logic [18:0]                key_vpn_o,
	output logic                       ins_we0_o,
	output logic                       ins_we1_o,
	output ipt_pte_t                   ins_entry_o
);

	localparam int IB = `IPT_INDEX_BITS;

	ipt_cfg_word_u wd;
	ipt_pte_t      stage;
	logic          cmd_wr;
	logic          probe_pend;
	logic          probe_done;
	logic          probe_hit;
	logic          probe_bank;
	logic [IB-1:0] probe_slot;

	assign wd = cfg_dat_i;
	assign cmd_wr = cfg_we_i && cfg_adr_i == `IPT_REG_CMD;

	// ====================
	// staged entry
	// ====================

	always_ff @(posedge clk) begin
		if (cfg_we_i && cfg_adr_i == `IPT_REG_ATTR) begin
			stage.asid <= wd.attr.asid;
			stage.last <= wd.attr.last;
			stage.drwx <= wd.attr.drwx;
		end
		if (cfg_we_i && cfg_adr_i == `IPT_REG_VPN)
			stage.vpn <= cfg_dat_i[18:0];
	end

	// the bank hashes the entry itself, so only the bank choice is needed here
	always_ff @(posedge clk) begin
		if (rst) begin
			ins_we0_o <= 1'b0;
			ins_we1_o <= 1'b0;
		end else begin
			ins_we0_o <= cmd_wr && wd.cmd.insert && !wd.cmd.bank;
			ins_we1_o <= cmd_wr && wd.cmd.insert && wd.cmd.bank;
		end
	end

	assign ins_entry_o = stage;

	// ====================
	// probe handling
	// ====================

	// requests own the lookup port, a probe waits for an idle cycle
	assign probe_issue_o = probe_pend && !req_i;

	assign key_asid_o = req_i ? vadr_i[63:56] : stage.asid;
	assign key_vpn_o  = req_i ? vadr_i[31:13] : stage.vpn;

	always_ff @(posedge clk) begin
		if (rst) begin
			probe_pend <= 1'b0;
			probe_done <= 1'b0;
		end else if (cmd_wr && wd.cmd.probe) begin
			// a new probe restarts the status
			probe_pend <= 1'b1;
			probe_done <= 1'b0;
		end else begin
			if (probe_issue_o)
				probe_pend <= 1'b0;
			if (probe_done_i)
				probe_done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (probe_done_i) begin
			probe_hit  <= probe_hit_i;
			probe_bank <= probe_bank_i;
			probe_slot <= probe_slot_i;
		end
	end

	// status word at the command address:
	// bit 0 done, bit 1 pending, bit 2 bank, bit 3 hit
	always_ff @(posedge clk) begin
		if (cfg_re_i) begin
			case (cfg_adr_i)
				`IPT_REG_CMD:
					cfg_dat_o <= {28'd0, probe_hit, probe_bank, probe_pend, probe_done};
				`IPT_REG_SLOT:
					cfg_dat_o <= {{(32 - IB){1'b0}}, probe_slot};
				`IPT_REG_ATTR:
					cfg_dat_o <= {stage.asid, stage.last, 19'd0, stage.drwx};
				default:
					cfg_dat_o <= {13'd0, stage.vpn};
			endcase
		end
	end

endmodule

// ==== verilog/ipt_bank.sv ====
`timescale 1ns/1ps
`include "ipt_macros.svh"

module ipt_bank import ipt_pkg::*; #(
	parameter int BANK_ID = 0
) (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       lookup_i,
	input  logic [7:0]                 key_asid_i,
	input  logic [18:0]                key_vpn_i,
	input  logic                       we_i,
	input  ipt_pte_t                   wentry_i,
	output logic                       hit_o,
	output logic [3:0]                 drwx_o,
	output logic [`IPT_INDEX_BITS-1:0] slot_o
);

	localparam int IB = `IPT_INDEX_BITS;

	ipt_pte_t      mem [2**IB];
	ipt_pte_t      rd_q;
	logic [IB-1:0] rd_idx;
	logic [IB-1:0] wr_idx;
	logic [IB-1:0] idx_q;
	logic [7:0]    asid_q;
	logic [18:0]   vpn_q;
	logic          lk_q;

	function automatic logic [IB-1:0] bank_hash(
		input logic [7:0]  asid,
		input logic [18:0] vpn
	);
		if (BANK_ID == 0)
			return ipt_hash0(vpn);
		else
			return ipt_hash1(asid, vpn);
	endfunction

	// inserts land in the same slot a later lookup of that key will read
	assign rd_idx = bank_hash(key_asid_i, key_vpn_i);
	assign wr_idx = bank_hash(wentry_i.asid, wentry_i.vpn);

	// ====================
	// stage 1, RAM access
	// ====================

	always_ff @(posedge clk) begin
		if (we_i)
			mem[wr_idx] <= wentry_i;
	end

	// a read colliding with a write sees the old entry
	always_ff @(posedge clk) begin
		if (lookup_i) begin
			rd_q   <= mem[rd_idx];
			idx_q  <= rd_idx;
			asid_q <= key_asid_i;
			vpn_q  <= key_vpn_i;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			lk_q <= 1'b0;
		else
			lk_q <= lookup_i;
	end

	// ====================
	// stage 2, tag compare
	// ====================

	always_ff @(posedge clk) begin
		if (rst)
			hit_o <= 1'b0;
		else
			hit_o <= lk_q && ipt_pte_valid(rd_q) && rd_q.asid == asid_q && rd_q.vpn == vpn_q;
	end

	always_ff @(posedge clk) begin
		drwx_o <= rd_q.drwx;
		slot_o <= idx_q;
	end

endmodule

// ==== verilog/ipt_resolve.sv ====
`timescale 1ns/1ps
`include "ipt_macros.svh"

module ipt_resolve (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       lookup_i,
	input  logic                       probe_i,
	input  logic [63:0]                vadr_i,
	input  logic                       we_i,
	input  logic                       ifetch_i,
	input  logic [1:0]                 ol_i,
	input  logic                       hit0_i,
	input  logic [3:0]                 drwx0_i,
	input  logic [`IPT_INDEX_BITS-1:0] slot0_i,
	input  logic                       hit1_i,
	input  logic [3:0]                 drwx1_i,
	input  logic [`IPT_INDEX_BITS-1:0] slot1_i,
	output logic                       resp_valid_o,
	output logic [31:0]                padr_o,
	output logic                       page_fault_o,
	output logic                       rdv_o,
	output logic                       wrv_o,
	output logic                       exv_o,
	output logic                       probe_done_o,
	output logic                       probe_hit_o,
	output logic                       probe_bank_o,
	output logic [`IPT_INDEX_BITS-1:0] probe_slot_o
);

	localparam int IB       = `IPT_INDEX_BITS;
	localparam int SB_DEPTH = `IPT_LATENCY - 1;
	localparam int T        = SB_DEPTH - 1;
	localparam int PAD_BITS = 32 - 1 - IB - 13;

	logic [SB_DEPTH-1:0] sb_valid;
	logic [SB_DEPTH-1:0] sb_probe;
	logic [SB_DEPTH-1:0] sb_bypass;
	logic [SB_DEPTH-1:0] sb_we;
	logic [SB_DEPTH-1:0] sb_ifetch;
	logic [31:0]         sb_lo32 [SB_DEPTH];
	logic                bypass;
	logic                tail_resp;
	logic                tail_xlat;
	logic [12:0]         tail_off;
	logic                any_hit;
	logic [3:0]          sel_drwx;

	// level 0 and the top I/O region are never translated, probes always are
	assign bypass = (ol_i == 2'd0 || vadr_i[31:24] == 8'hFF) && !probe_i;

	// ====================
	// sideband delay
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			sb_valid <= '0;
		end else begin
			sb_valid[0] <= lookup_i;
			for (int i = 1; i < SB_DEPTH; i++)
				sb_valid[i] <= sb_valid[i-1];
		end
	end

	always_ff @(posedge clk) begin
		sb_probe[0]  <= probe_i;
		sb_bypass[0] <= bypass;
		sb_we[0]     <= we_i;
		sb_ifetch[0] <= ifetch_i;
		sb_lo32[0]   <= vadr_i[31:0];
		for (int i = 1; i < SB_DEPTH; i++) begin
			sb_probe[i]  <= sb_probe[i-1];
			sb_bypass[i] <= sb_bypass[i-1];
			sb_we[i]     <= sb_we[i-1];
			sb_ifetch[i] <= sb_ifetch[i-1];
			sb_lo32[i]   <= sb_lo32[i-1];
		end
	end

	// ====================
	// result stage
	// ====================

	assign tail_resp = sb_valid[T] && !sb_probe[T];
	assign tail_xlat = tail_resp && !sb_bypass[T];
	assign tail_off  = sb_lo32[T][12:0];
	assign any_hit   = hit0_i || hit1_i;
	// bank 0 has priority when both banks match
	assign sel_drwx  = hit0_i ? drwx0_i : drwx1_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			resp_valid_o <= 1'b0;
			page_fault_o <= 1'b0;
			rdv_o        <= 1'b0;
			wrv_o        <= 1'b0;
			exv_o        <= 1'b0;
			probe_done_o <= 1'b0;
		end else begin
			resp_valid_o <= tail_resp;
			probe_done_o <= sb_valid[T] && sb_probe[T];
			page_fault_o <= tail_xlat && !any_hit;
			wrv_o        <= tail_xlat && any_hit && sb_we[T] && !sel_drwx[1];
			rdv_o        <= tail_xlat && any_hit && !sb_we[T] && !sel_drwx[2];
			exv_o        <= tail_xlat && any_hit && sb_ifetch[T] && !sel_drwx[0];
		end
	end

	// physical address is bank bit, slot and page offset
	always_ff @(posedge clk) begin
		if (sb_bypass[T])
			padr_o <= sb_lo32[T];
		else if (hit0_i)
			padr_o <= {{PAD_BITS{1'b0}}, 1'b0, slot0_i, tail_off};
		else if (hit1_i)
			padr_o <= {{PAD_BITS{1'b0}}, 1'b1, slot1_i, tail_off};
		else
			padr_o <= '0;
		probe_hit_o  <= any_hit;
		probe_bank_o <= !hit0_i && hit1_i;
		probe_slot_o <= hit0_i ? slot0_i : slot1_i;
	end

endmodule

// ==== verilog/ipt_mmu.sv ====
`timescale 1ns/1ps
`include "ipt_macros.svh"

module ipt_mmu import ipt_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        req_i,
	input  logic [63:0] vadr_i,
	input  logic        we_i,
	input  logic        ifetch_i,
	input  logic [1:0]  ol_i,
	output logic        resp_valid_o,
	output logic [31:0] padr_o,
	output logic        page_fault_o,
	output logic        rdv_o,
	output logic        wrv_o,
	output logic        exv_o,
	input  logic        cfg_we_i,
	input  logic        cfg_re_i,
	input  logic [1:0]  cfg_adr_i,
	input  logic [31:0] cfg_dat_i,
	output logic [31:0] cfg_dat_o
);

	localparam int IB = `IPT_INDEX_BITS;

	logic          probe_issue;
	logic          lookup;
	logic [7:0]    key_asid;
	logic [18:0]   key_vpn;
	logic          ins_we0;
	logic          ins_we1;
	ipt_pte_t      ins_entry;
	logic          hit0;
	logic          hit1;
	logic [3:0]    drwx0;
	logic [3:0]    drwx1;
	logic [IB-1:0] slot0;
	logic [IB-1:0] slot1;
	logic          probe_done;
	logic          probe_hit;
	logic          probe_bank;
	logic [IB-1:0] probe_slot;

	// probes only fill idle request cycles, so the two never collide
	assign lookup = req_i || probe_issue;

	ipt_cfg_regs cfg0 (
		.clk, .rst, .cfg_we_i, .cfg_re_i, .cfg_adr_i, .cfg_dat_i, .cfg_dat_o,
		.req_i, .vadr_i,
		.probe_done_i(probe_done), .probe_hit_i(probe_hit),
		.probe_bank_i(probe_bank), .probe_slot_i(probe_slot),
		.probe_issue_o(probe_issue), .key_asid_o(key_asid), .key_vpn_o(key_vpn),
		.ins_we0_o(ins_we0), .ins_we1_o(ins_we1), .ins_entry_o(ins_entry)
	);

	ipt_bank #(.BANK_ID(0)) bank0 (
		.clk, .rst, .lookup_i(lookup), .key_asid_i(key_asid), .key_vpn_i(key_vpn),
		.we_i(ins_we0), .wentry_i(ins_entry),
		.hit_o(hit0), .drwx_o(drwx0), .slot_o(slot0)
	);

	ipt_bank #(.BANK_ID(1)) bank1 (
		.clk, .rst, .lookup_i(lookup), .key_asid_i(key_asid), .key_vpn_i(key_vpn),
		.we_i(ins_we1), .wentry_i(ins_entry),
		.hit_o(hit1), .drwx_o(drwx1), .slot_o(slot1)
	);

	ipt_resolve res0 (
		.clk, .rst, .lookup_i(lookup), .probe_i(probe_issue),
		.vadr_i, .we_i, .ifetch_i, .ol_i,
		.hit0_i(hit0), .drwx0_i(drwx0), .slot0_i(slot0),
		.hit1_i(hit1), .drwx1_i(drwx1), .slot1_i(slot1),
		.resp_valid_o, .padr_o, .page_fault_o, .rdv_o, .wrv_o, .exv_o,
		.probe_done_o(probe_done), .probe_hit_o(probe_hit),
		.probe_bank_o(probe_bank), .probe_slot_o(probe_slot)
	);

endmodule

// ==== verification/ipt_mmu_asserts.sv ====
`timescale 1ns/1ps
`include "ipt_macros.svh"

module ipt_mmu_asserts (
	input logic clk,
	input logic rst,
	input logic req_i,
	input logic resp_valid_i,
	input logic page_fault_i,
	input logic rdv_i,
	input logic wrv_i,
	input logic exv_i,
	input logic probe_issue_i,
	input logic probe_pend_i,
	input logic probe_done_i,
	input logic ins_we_i
);

	int fail_cnt = 0;

	task automatic flag_error(input string msg);
		$error("%s", msg);
		fail_cnt++;
	endtask

	// everything registered comes up idle one cycle after reset is sampled
	reset_idle: assert property (@(posedge clk) rst |=> !resp_valid_i && !page_fault_i
		&& !rdv_i && !wrv_i && !exv_i && !probe_pend_i && !probe_done_i && !ins_we_i)
		else flag_error("DUT state active after reset");

	// ====================
	// request latency
	// ====================

	req_to_resp: assert property (@(posedge clk) disable iff (rst)
		req_i |-> ##`IPT_LATENCY resp_valid_i)
		else flag_error("response missing the fixed latency after a request");

	resp_from_req: assert property (@(posedge clk) disable iff (rst)
		resp_valid_i |-> $past(req_i, `IPT_LATENCY))
		else flag_error("response without a request at the fixed latency");

	// a probe completes after the fixed latency and never shows up as a response
	probe_slot: assert property (@(posedge clk) disable iff (rst)
		probe_issue_i |-> ##`IPT_LATENCY (probe_done_i && !resp_valid_i))
		else flag_error("probe did not complete in time or produced a response");

	// ====================
	// flag rules
	// ====================

	flags_need_resp: assert property (@(posedge clk) disable iff (rst)
		(page_fault_i || rdv_i || wrv_i || exv_i) |-> resp_valid_i)
		else flag_error("fault flag high without a response");

	fault_alone: assert property (@(posedge clk) disable iff (rst)
		page_fault_i |-> !(rdv_i || wrv_i || exv_i))
		else flag_error("page fault together with a violation flag");

endmodule

bind ipt_mmu ipt_mmu_asserts asserts0 (
	.clk, .rst, .req_i,
	.resp_valid_i(resp_valid_o), .page_fault_i(page_fault_o),
	.rdv_i(rdv_o), .wrv_i(wrv_o), .exv_i(exv_o),
	.probe_issue_i(probe_issue), .probe_pend_i(cfg0.probe_pend),
	.probe_done_i(probe_done), .ins_we_i(ins_we0 || ins_we1)
);

// ==== verification/ipt_mmu_tb.sv ====
`timescale 1ns/1ps
`include "ipt_macros.svh"

module ipt_mmu_tb;

	localparam int IB        = `IPT_INDEX_BITS;
	localparam int PAD       = 32 - 1 - IB - 13;
	localparam int RAND_REQS = 200;
	// table clear, directed traffic and random traffic at 40 ns, doubled
	localparam longint WATCHDOG_NS = 2 * 40 * (6 * 2**IB + 300 + RAND_REQS);

	logic          clk;
	logic          rst;
	logic          req_i;
	logic [63:0]   vadr_i;
	logic          we_i;
	logic          ifetch_i;
	logic [1:0]    ol_i;
	logic          resp_valid_o;
	logic [31:0]   padr_o;
	logic          page_fault_o;
	logic          rdv_o;
	logic          wrv_o;
	logic          exv_o;
	logic          cfg_we_i;
	logic          cfg_re_i;
	logic [1:0]    cfg_adr_i;
	logic [31:0]   cfg_dat_i;
	logic [31:0]   cfg_dat_o;
	logic [31:0]   tbl [2][2**IB];
	logic [35:0]   exp_q [$];
	logic [35:0]   got;
	logic [35:0]   want;
	logic [26:0]   keys [5];
	logic [31:0]   rd;
	logic [63:0]   rva;
	logic          p_hit;
	logic          p_bank;
	logic [IB-1:0] p_slot;
	integer        seed;
	integer        r;

	ipt_mmu dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "run stopped");
	endtask

	task automatic mismatch(input string msg);
		abort_run($sformatf("Error at %0t ns: %s", $time, msg));
	endtask

	function automatic logic [IB-1:0] slot_of(input int b, input logic [7:0] asid,
			input logic [18:0] vpn);
		if (b == 0)
			return vpn[IB-1:0];
		return vpn[IB-1:0] ^ {asid, 1'b1};
	endfunction

	// bank 0 is searched first, so it wins when both banks hold the key
	function automatic logic find_entry(input logic [7:0] asid, input logic [18:0] vpn,
			output logic bank, output logic [IB-1:0] slot);
		logic [31:0] e;
		for (int b = 0; b < 2; b++) begin
			slot = slot_of(b, asid, vpn);
			bank = b[0];
			e = tbl[b][slot];
			if (e[2:0] != 3'd0 && e[31:24] == asid && e[22:4] == vpn)
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// packed as padr, page fault, rdv, wrv, exv
	function automatic logic [35:0] expected_resp(input logic [63:0] va, input logic w,
			input logic ix, input logic [1:0] o);
		logic          bank;
		logic [IB-1:0] slot;
		logic [3:0]    p;
		if (o == 2'd0 || va[31:24] == 8'hff)
			return {va[31:0], 4'b0000};
		if (!find_entry(va[63:56], va[31:13], bank, slot))
			return {32'd0, 4'b1000};
		p = tbl[bank][slot][3:0];
		return {{PAD{1'b0}}, bank, slot, va[12:0], 1'b0, !w && !p[2], w && !p[1], ix && !p[0]};
	endfunction

	function automatic logic [63:0] va_of(input logic [26:0] key, input logic [12:0] off);
		return {key[26:19], 24'h00_0000, key[18:0], off};
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic cfg_write(input logic [1:0] adr, input logic [31:0] dat);
		cfg_we_i  = 1'b1;
		cfg_adr_i = adr;
		cfg_dat_i = dat;
		next_cycle();
		cfg_we_i = 1'b0;
	endtask

	task automatic read_reg(input logic [1:0] adr, output logic [31:0] dat);
		cfg_re_i  = 1'b1;
		cfg_adr_i = adr;
		next_cycle();
		cfg_re_i = 1'b0;
		dat = cfg_dat_o;
	endtask

	task automatic insert(input logic bank, input logic [7:0] asid, input logic [18:0] vpn,
			input logic [3:0] drwx);
		cfg_write(`IPT_REG_ATTR, {asid, 1'b0, 19'd0, drwx});
		cfg_write(`IPT_REG_VPN, {13'd0, vpn});
		cfg_write(`IPT_REG_CMD, {29'd0, bank, 2'b01});
		tbl[bank][slot_of(bank, asid, vpn)] = {asid, 1'b0, vpn, drwx};
	endtask

	task automatic request(input logic [63:0] va, input logic w, input logic ix,
			input logic [1:0] o);
		req_i    = 1'b1;
		vadr_i   = va;
		we_i     = w;
		ifetch_i = ix;
		ol_i     = o;
		exp_q.push_back(expected_resp(va, w, ix, o));
		next_cycle();
		req_i = 1'b0;
	endtask

	// outputs settle well before the falling edge
	always @(negedge clk) begin
		if (!rst && resp_valid_o) begin
			assert (exp_q.size() != 0) else
				abort_run("a response came without a pending request");
			got  = {padr_o, page_fault_o, rdv_o, wrv_o, exv_o};
			want = exp_q.pop_front();
			assert (got === want) else
				mismatch($sformatf("padr and flags %h, expected %h", got, want));
		end
		assert (dut0.asserts0.fail_cnt == 0) else
			abort_run("a bound assertion on the DUT failed");
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		seed      = 32'hf9d4_b2b0;
		rst       = 1'b1;
		req_i     = 1'b0;
		vadr_i    = '0;
		we_i      = 1'b0;
		ifetch_i  = 1'b0;
		ol_i      = 2'd0;
		cfg_we_i  = 1'b0;
		cfg_re_i  = 1'b0;
		cfg_adr_i = 2'd0;
		cfg_dat_i = '0;
		repeat (10) @(posedge clk);
		#2;
		rst = 1'b0;

		// every slot of both banks starts as an invalid entry
		for (int i = 0; i < 2**IB; i++) begin
			insert(1'b0, 8'h00, 19'(i), 4'b0000);
			insert(1'b1, 8'h00, 19'(i), 4'b0000);
		end
		keys[0] = {8'h12, 19'h00345};
		keys[1] = {8'h12, 19'h01046};
		keys[2] = {8'h33, 19'h02047};
		keys[3] = {8'h44, 19'h00777};
		keys[4] = {8'h21, 19'h00150};
		insert(1'b0, 8'h12, 19'h00345, 4'b0111);
		insert(1'b0, 8'h12, 19'h01046, 4'b0100);
		insert(1'b0, 8'h33, 19'h02047, 4'b1010);
		insert(1'b0, 8'h44, 19'h00777, 4'b0110);
		insert(1'b1, 8'h44, 19'h00777, 4'b0111);
		// the last insert stays staged and is the probe key
		insert(1'b1, 8'h21, 19'h00150, 4'b0111);
		next_cycle();

		// ====================
		// directed lookups
		// ====================
		request({8'h12, 24'h0, 32'h0068_a0a8}, 1'b0, 1'b0, 2'd0);
		request({8'h12, 24'h0, 32'hff12_3456}, 1'b1, 1'b1, 2'd3);
		request(va_of(keys[0], 13'h0a8), 1'b0, 1'b1, 2'd3);
		request(va_of(keys[0], 13'h1ff), 1'b1, 1'b0, 2'd1);
		request(va_of(keys[1], 13'h010), 1'b1, 1'b1, 2'd2);
		request(va_of(keys[2], 13'h004), 1'b0, 1'b1, 2'd3);
		request(va_of(keys[4], 13'h123), 1'b1, 1'b0, 2'd3);
		request(va_of(keys[3], 13'h0ee), 1'b0, 1'b1, 2'd3);
		// wrong ASID, wrong VPN, then a slot holding an invalid entry
		request(va_of({8'h13, 19'h00345}, 13'h0), 1'b0, 1'b0, 2'd3);
		request(va_of({8'h12, 19'h00346}, 13'h0), 1'b0, 1'b0, 2'd3);
		request(va_of({8'h00, 19'h00010}, 13'h0), 1'b0, 1'b0, 2'd3);
		repeat (`IPT_LATENCY + 1) next_cycle();

		// the probe stays pending behind the burst
		cfg_write(`IPT_REG_CMD, 32'h0000_0002);
		for (int k = 0; k < 5; k++)
			request(va_of(keys[k], 13'(k)), 1'b0, 1'b0, 2'd3);
		do
			read_reg(`IPT_REG_CMD, rd);
		while (!rd[0]);
		p_hit = find_entry(keys[4][26:19], keys[4][18:0], p_bank, p_slot);
		assert (rd[3] == p_hit && rd[2] == p_bank) else
			mismatch($sformatf("probe status %h, expected hit %b bank %b", rd, p_hit, p_bank));
		read_reg(`IPT_REG_SLOT, rd);
		assert (rd[IB-1:0] == p_slot) else
			mismatch($sformatf("probe slot %h, expected %h", rd[IB-1:0], p_slot));

		// ====================
		// random back-to-back traffic
		// ====================
		for (int n = 0; n < RAND_REQS; n++) begin
			r   = $random(seed);
			rva = {$random(seed), $random(seed)};
			if (r[4])
				rva = va_of(keys[r[7:5] % 5], rva[12:0]);
			request(rva, r[2], r[3], r[1:0]);
		end
		repeat (`IPT_LATENCY + 1) next_cycle();

		if (exp_q.size() != 0 || dut0.asserts0.fail_cnt != 0) begin
			abort_run("responses went missing or a bound assertion failed");
		end else begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/ipt_pkg.sv
verilog/ipt_cfg_regs.sv
verilog/ipt_bank.sv
verilog/ipt_resolve.sv
verilog/ipt_mmu.sv
verification/ipt_mmu_asserts.sv
verification/ipt_mmu_tb.sv

// ==== Bender.yml ====
package:
  name: ipt_mmu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ipt_pkg.sv
      - verilog/ipt_cfg_regs.sv
      - verilog/ipt_bank.sv
      - verilog/ipt_resolve.sv
      - verilog/ipt_mmu.sv
      - target: simulation
        files:
          - verification/ipt_mmu_asserts.sv
          - verification/ipt_mmu_tb.sv
